/* logic/flip_pkg.sv */
// Spin update shared definitions
package flip_pkg;

    // Vector and queue sizes
    localparam int NUM_SPIN   = 16;
    localparam int SPIN_DEPTH = 2;
    localparam int ENERGY_W   = 16;

    // Icon table geometry
    localparam int ICON_DEPTH = 8;
    localparam int ICON_AW    = 3;

    typedef logic [NUM_SPIN-1:0]        spin_t;
    typedef logic signed [ENERGY_W-1:0] energy_t;
    // One extra bit so the icon count itself fits
    typedef logic [ICON_AW:0]           icon_addr_t;

    // Slot pointer and occupancy count for the SPIN_DEPTH queues
    typedef logic [$clog2(SPIN_DEPTH)-1:0]   slot_t;
    typedef logic [$clog2(SPIN_DEPTH+1)-1:0] cnt_t;

    // Reference energy preset, most positive value
    localparam energy_t ENERGY_MAX = {1'b0, {(ENERGY_W-1){1'b1}}};

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_READ,
        FE_EMIT
    } fe_state_e;

    typedef enum logic [1:0] {
        CMPT_IDLE,
        CMPT_RUN,
        CMPT_DRAIN
    } cmpt_state_e;

endpackage

/* logic/spin_stream_if.sv */
// Spin push stream
`timescale 1ns/1ps

interface spin_stream_if;
    import flip_pkg::*;

    logic  valid;
    logic  ready;
    spin_t spin;
    // Re-enqueue the oldest shadow spin, payload ignored
    logic  push_none;

    modport src (
        output valid,
        output spin,
        output push_none,
        input  ready
    );

    modport dst (
        input  valid,
        input  spin,
        input  push_none,
        output ready
    );

endinterface

/* logic/energy_fifo_maintainer.sv */
// Candidate energy maintainer
`timescale 1ns/1ps

module energy_fifo_maintainer (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             en_comparison_i,
    input  logic             spin_valid_i,
    input  flip_pkg::spin_t   spin_i,
    output logic             spin_ready_o,
    input  logic             energy_valid_i,
    input  flip_pkg::energy_t energy_i,
    output logic             energy_ready_o,
    spin_stream_if.src       push
);
    import flip_pkg::*;

    // Candidates waiting for their energy
    spin_t   cand_mem [SPIN_DEPTH];
    slot_t   cand_wr_q;
    slot_t   cand_rd_q;
    cnt_t    cand_cnt_q;
    cnt_t    cand_cnt_d;
    // Spin input opens one cycle after reset
    logic    spin_rdy_q;
    // Best energy seen so far, one per slot
    energy_t ref_q [SPIN_DEPTH];
    slot_t   slot_q;
    logic    spin_hs;
    logic    energy_hs;
    logic    accept;

    assign spin_ready_o = spin_rdy_q;
    // Energy only pairs with a waiting candidate, and not over a pending push
    assign energy_ready_o = (cand_cnt_q != '0) & ~push.valid;
    assign spin_hs = spin_valid_i & spin_ready_o;
    assign energy_hs = energy_valid_i & energy_ready_o;
    // Only a strictly lower energy replaces the old spin
    assign accept = ~en_comparison_i | (energy_i < ref_q[slot_q]);

    always_comb begin
        cand_cnt_d = cand_cnt_q;
        if (spin_hs && !energy_hs) begin
            cand_cnt_d = cand_cnt_q + 1'b1;
        end else if (energy_hs && !spin_hs) begin
            cand_cnt_d = cand_cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cand_wr_q  <= '0;
            cand_rd_q  <= '0;
            cand_cnt_q <= '0;
            spin_rdy_q <= 1'b0;
            slot_q     <= '0;
            push.valid <= 1'b0;
            for (int i = 0; i < SPIN_DEPTH; i++) begin
                ref_q[i] <= ENERGY_MAX;
            end
        end else if (flush_i) begin
            cand_wr_q  <= '0;
            cand_rd_q  <= '0;
            cand_cnt_q <= '0;
            spin_rdy_q <= 1'b1;
            slot_q     <= '0;
            push.valid <= 1'b0;
            for (int i = 0; i < SPIN_DEPTH; i++) begin
                ref_q[i] <= ENERGY_MAX;
            end
        end else begin
            if (spin_hs) begin
                cand_wr_q <= cand_wr_q + 1'b1;
            end
            cand_cnt_q <= cand_cnt_d;
            spin_rdy_q <= (cand_cnt_d != cnt_t'(SPIN_DEPTH));
            if (energy_hs) begin
                cand_rd_q <= cand_rd_q + 1'b1;
                // Slots rotate in FIFO order
                slot_q <= slot_q + 1'b1;
                if (accept) begin
                    ref_q[slot_q] <= energy_i;
                end
            end
            // Push held until the spin FIFO takes it
            if (energy_hs) begin
                push.valid <= 1'b1;
            end else if (push.ready) begin
                push.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_hs) begin
            cand_mem[cand_wr_q] <= spin_i;
        end
        if (energy_hs) begin
            push.spin      <= cand_mem[cand_rd_q];
            push.push_none <= ~accept;
        end
    end

endmodule

/* logic/spin_fifo_maintainer.sv */
// Spin FIFO with restore queue
`timescale 1ns/1ps

module spin_fifo_maintainer (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           flush_i,
    input  logic           cmpt_en_i,
    input  logic           icon_finish_i,
    input  logic           host_readout_i,
    spin_stream_if.dst     push,
    output logic           pop_valid_o,
    output flip_pkg::spin_t pop_spin_o,
    input  logic           pop_ready_i,
    output logic           cmpt_busy_o
);
    import flip_pkg::*;

    cmpt_state_e state_q;
    // Main FIFO, pointers wrap since the depth is a power of two
    spin_t       fifo_mem [SPIN_DEPTH];
    slot_t       wr_ptr_q;
    slot_t       rd_ptr_q;
    cnt_t        count_q;
    // Spins popped during a computation and not yet resolved
    spin_t       shadow_mem [SPIN_DEPTH];
    slot_t       sh_wr_ptr_q;
    slot_t       sh_rd_ptr_q;
    logic        busy;
    logic        push_hs;
    logic        pop_hs;
    logic        sh_store;
    logic        sh_take;
    spin_t       push_data;

    assign busy = (state_q != CMPT_IDLE);
    assign cmpt_busy_o = busy;

    assign push.ready = (count_q != cnt_t'(SPIN_DEPTH));
    // Pops open during a computation or a host readout
    assign pop_valid_o = (count_q != '0) & (busy | host_readout_i);
    assign pop_spin_o = fifo_mem[rd_ptr_q];

    assign push_hs = push.valid & push.ready;
    assign pop_hs = pop_valid_o & pop_ready_i;

    // Every resolved slot retires its shadow entry
    assign sh_store = pop_hs & busy;
    assign sh_take = push_hs & busy;
    // Rejected candidate, restore the spin it came from
    assign push_data = push.push_none ? shadow_mem[sh_rd_ptr_q] : push.spin;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= CMPT_IDLE;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            sh_wr_ptr_q <= '0;
            sh_rd_ptr_q <= '0;
        end else if (flush_i) begin
            state_q     <= CMPT_IDLE;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            sh_wr_ptr_q <= '0;
            sh_rd_ptr_q <= '0;
        end else begin
            if (push_hs) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_hs) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_hs != pop_hs) begin
                count_q <= push_hs ? count_q + 1'b1 : count_q - 1'b1;
            end
            if (sh_store) begin
                sh_wr_ptr_q <= sh_wr_ptr_q + 1'b1;
            end
            if (sh_take) begin
                sh_rd_ptr_q <= sh_rd_ptr_q + 1'b1;
            end

            case (state_q)
                CMPT_IDLE: begin
                    if (cmpt_en_i) begin
                        state_q <= CMPT_RUN;
                    end
                end
                // Last icon emitted, wait for the slots to come home
                CMPT_RUN: begin
                    if (icon_finish_i) begin
                        state_q <= CMPT_DRAIN;
                    end
                end
                CMPT_DRAIN: begin
                    if (count_q == cnt_t'(SPIN_DEPTH)) begin
                        state_q <= CMPT_IDLE;
                    end
                end
                default: state_q <= CMPT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_hs) begin
            fifo_mem[wr_ptr_q] <= push_data;
        end
        if (sh_store) begin
            shadow_mem[sh_wr_ptr_q] <= pop_spin_o;
        end
    end

endmodule

/* logic/flip_engine.sv */
// Icon flip engine
`timescale 1ns/1ps

module flip_engine (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic                 cmpt_busy_i,
    input  logic                 flip_disable_i,
    input  logic                 prev_valid_i,
    input  flip_pkg::spin_t       prev_spin_i,
    output logic                 prev_ready_o,
    output logic                 flipped_valid_o,
    output flip_pkg::spin_t       flipped_spin_o,
    input  logic                 flipped_ready_i,
    output logic                 flip_ren_o,
    output flip_pkg::icon_addr_t flip_raddr_o,
    input  flip_pkg::spin_t       flip_rdata_i,
    input  flip_pkg::icon_addr_t icon_count_i,
    output logic                 icon_finish_o
);
    import flip_pkg::*;

    fe_state_e  state_q;
    icon_addr_t addr_q;
    icon_addr_t last_addr;
    // Popped spin, flipped in place once the icon arrives
    spin_t      spin_q;
    logic       flip_q;
    logic       last_q;
    logic       flip_now;
    logic       pop_hs;

    assign flip_now = cmpt_busy_i & ~flip_disable_i;
    assign last_addr = icon_count_i - 1'b1;

    // One spin in flight, no pops past the last icon
    assign prev_ready_o = (state_q == FE_IDLE) & (~cmpt_busy_i | (addr_q < icon_count_i));
    assign pop_hs = prev_valid_i & prev_ready_o;

    // Icon read issued together with the pop
    assign flip_ren_o = pop_hs & flip_now;
    assign flip_raddr_o = addr_q;

    assign flipped_valid_o = (state_q == FE_EMIT);
    assign flipped_spin_o = spin_q;
    assign icon_finish_o = flipped_valid_o & flipped_ready_i & last_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= FE_IDLE;
            addr_q  <= '0;
            flip_q  <= 1'b0;
            last_q  <= 1'b0;
        end else if (flush_i) begin
            state_q <= FE_IDLE;
            addr_q  <= '0;
            flip_q  <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            case (state_q)
                FE_IDLE: begin
                    if (pop_hs) begin
                        state_q <= FE_READ;
                    end
                end
                FE_READ: state_q <= FE_EMIT;
                // Hold the output until the energy side takes it
                FE_EMIT: begin
                    if (flipped_ready_i) begin
                        state_q <= FE_IDLE;
                    end
                end
                default: state_q <= FE_IDLE;
            endcase

            // Address restarts with every computation
            if (!cmpt_busy_i) begin
                addr_q <= '0;
            end else if (pop_hs) begin
                addr_q <= addr_q + 1'b1;
            end

            if (pop_hs) begin
                flip_q <= flip_now;
                last_q <= cmpt_busy_i & (addr_q == last_addr);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_hs) begin
            spin_q <= prev_spin_i;
        end else if ((state_q == FE_READ) && flip_q) begin
            spin_q <= spin_q ^ flip_rdata_i;
        end
    end

endmodule

/* logic/flip_icon_mem.sv */
// Flip icon table
`timescale 1ns/1ps

module flip_icon_mem (
    input  logic                           clk_i,
    input  logic                           we_i,
    input  logic [flip_pkg::ICON_AW-1:0]   waddr_i,
    input  flip_pkg::spin_t                 wdata_i,
    input  logic                           ren_i,
    input  logic [flip_pkg::ICON_AW-1:0]   raddr_i,
    output flip_pkg::spin_t                 rdata_o
);
    import flip_pkg::*;

    // One icon per address, written by the host
    spin_t icon_mem [ICON_DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            icon_mem[waddr_i] <= wdata_i;
        end
    end

    // Registered read, data one cycle after ren
    always_ff @(posedge clk_i) begin
        if (ren_i) begin
            rdata_o <= icon_mem[raddr_i];
        end
    end

endmodule

/* logic/flip_manager.sv */
// Flip manager
`timescale 1ns/1ps

module flip_manager (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic                 en_comparison_i,
    input  logic                 cmpt_en_i,
    output logic                 cmpt_idle_o,
    input  logic                 host_readout_i,
    input  logic                 spin_configure_valid_i,
    input  flip_pkg::spin_t       spin_configure_i,
    output logic                 spin_configure_ready_o,
    output logic                 spin_pop_valid_o,
    output flip_pkg::spin_t       spin_pop_o,
    input  logic                 spin_pop_ready_i,
    input  logic                 spin_valid_i,
    input  flip_pkg::spin_t       spin_i,
    output logic                 spin_ready_o,
    input  logic                 energy_valid_i,
    output logic                 energy_ready_o,
    input  flip_pkg::energy_t     energy_i,
    output logic                 flip_ren_o,
    output flip_pkg::icon_addr_t flip_raddr_o,
    input  flip_pkg::icon_addr_t icon_count_i,
    input  flip_pkg::spin_t       flip_rdata_i,
    input  logic                 flip_disable_i
);
    import flip_pkg::*;

    logic  cmpt_busy;
    logic  icon_finish;
    // FIFO to engine link
    logic  fifo_pop_valid;
    spin_t fifo_pop_spin;
    logic  fifo_pop_ready;

    spin_stream_if en_push ();
    spin_stream_if fifo_push ();

    assign cmpt_idle_o = ~cmpt_busy;

    // Energy side owns the FIFO during a computation and the host owns it otherwise
    assign fifo_push.valid = cmpt_busy ? en_push.valid : spin_configure_valid_i;
    assign fifo_push.spin = cmpt_busy ? en_push.spin : spin_configure_i;
    assign fifo_push.push_none = cmpt_busy & en_push.push_none;
    assign en_push.ready = cmpt_busy & fifo_push.ready;
    assign spin_configure_ready_o = fifo_push.ready & cmpt_idle_o;

    energy_fifo_maintainer u_energy_fifo_maintainer (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .en_comparison_i (en_comparison_i),
        .spin_valid_i    (spin_valid_i),
        .spin_i          (spin_i),
        .spin_ready_o    (spin_ready_o),
        .energy_valid_i  (energy_valid_i),
        .energy_i        (energy_i),
        .energy_ready_o  (energy_ready_o),
        .push            (en_push)
    );

    spin_fifo_maintainer u_spin_fifo_maintainer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .cmpt_en_i      (cmpt_en_i),
        .icon_finish_i  (icon_finish),
        .host_readout_i (host_readout_i),
        .push           (fifo_push),
        .pop_valid_o    (fifo_pop_valid),
        .pop_spin_o     (fifo_pop_spin),
        .pop_ready_i    (fifo_pop_ready),
        .cmpt_busy_o    (cmpt_busy)
    );

    flip_engine u_flip_engine (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .cmpt_busy_i     (cmpt_busy),
        .flip_disable_i  (flip_disable_i),
        .prev_valid_i    (fifo_pop_valid),
        .prev_spin_i     (fifo_pop_spin),
        .prev_ready_o    (fifo_pop_ready),
        .flipped_valid_o (spin_pop_valid_o),
        .flipped_spin_o  (spin_pop_o),
        .flipped_ready_i (spin_pop_ready_i),
        .flip_ren_o      (flip_ren_o),
        .flip_raddr_o    (flip_raddr_o),
        .flip_rdata_i    (flip_rdata_i),
        .icon_count_i    (icon_count_i),
        .icon_finish_o   (icon_finish)
    );

endmodule

/* logic/ising_flip_top.sv */
// Ising spin update top
`timescale 1ns/1ps

module ising_flip_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  logic                         en_comparison_i,
    input  logic                         flip_disable_i,
    input  logic                         cmpt_en_i,
    output logic                         cmpt_idle_o,
    input  logic                         host_readout_i,
    input  logic                         spin_configure_valid_i,
    input  flip_pkg::spin_t               spin_configure_i,
    output logic                         spin_configure_ready_o,
    output logic                         spin_pop_valid_o,
    output flip_pkg::spin_t               spin_pop_o,
    input  logic                         spin_pop_ready_i,
    input  logic                         spin_valid_i,
    input  flip_pkg::spin_t               spin_i,
    output logic                         spin_ready_o,
    input  logic                         energy_valid_i,
    input  flip_pkg::energy_t             energy_i,
    output logic                         energy_ready_o,
    input  logic                         icon_we_i,
    input  logic [flip_pkg::ICON_AW-1:0] icon_waddr_i,
    input  flip_pkg::spin_t               icon_wdata_i,
    input  flip_pkg::icon_addr_t         icon_count_i
);
    import flip_pkg::*;

    // Icon read path between manager and table
    logic       flip_ren;
    icon_addr_t flip_raddr;
    spin_t      flip_rdata;

    flip_manager u_flip_manager (
        .clk_i                  (clk_i),
        .rst_n_i                (rst_n_i),
        .flush_i                (flush_i),
        .en_comparison_i        (en_comparison_i),
        .cmpt_en_i              (cmpt_en_i),
        .cmpt_idle_o            (cmpt_idle_o),
        .host_readout_i         (host_readout_i),
        .spin_configure_valid_i (spin_configure_valid_i),
        .spin_configure_i       (spin_configure_i),
        .spin_configure_ready_o (spin_configure_ready_o),
        .spin_pop_valid_o       (spin_pop_valid_o),
        .spin_pop_o             (spin_pop_o),
        .spin_pop_ready_i       (spin_pop_ready_i),
        .spin_valid_i           (spin_valid_i),
        .spin_i                 (spin_i),
        .spin_ready_o           (spin_ready_o),
        .energy_valid_i         (energy_valid_i),
        .energy_ready_o         (energy_ready_o),
        .energy_i               (energy_i),
        .flip_ren_o             (flip_ren),
        .flip_raddr_o           (flip_raddr),
        .icon_count_i           (icon_count_i),
        .flip_rdata_i           (flip_rdata),
        .flip_disable_i         (flip_disable_i)
    );

    // Reads stay below the icon count, so the top address bit is clear
    flip_icon_mem u_flip_icon_mem (
        .clk_i   (clk_i),
        .we_i    (icon_we_i),
        .waddr_i (icon_waddr_i),
        .wdata_i (icon_wdata_i),
        .ren_i   (flip_ren),
        .raddr_i (flip_raddr[ICON_AW-1:0]),
        .rdata_o (flip_rdata)
    );

endmodule

/* test/flip_manager_properties.sv */
// Flip manager assertions
`timescale 1ns/1ps

module flip_manager_properties (
    input logic            clk_i,
    input logic            rst_n_i,
    input logic            flush_i,
    input logic            cmpt_en_i,
    input logic            cmpt_idle_i,
    input logic            cfg_ready_i,
    input logic            pop_valid_i,
    input flip_pkg::spin_t pop_spin_i,
    input logic            pop_ready_i,
    input logic            flip_ren_i
);

    // Emitted spin holds while the energy side stalls
    pop_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        pop_valid_i && !pop_ready_i |=> pop_valid_i && $stable(pop_spin_i))
        else $error("spin pop output changed before it was taken");

    // A start locks out host loads from the next cycle on
    cfg_locked_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        cmpt_idle_i && cmpt_en_i |=> !cmpt_idle_i && !cfg_ready_i)
        else $error("computation start did not lock out configuration");

    // No icon reads outside a computation
    ren_idle_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmpt_idle_i |-> !flip_ren_i)
        else $error("icon read while idle");

    reset_idle_a: assert property (@(posedge clk_i) $rose(rst_n_i) |-> cmpt_idle_i)
        else $error("not idle after reset");

endmodule

bind flip_manager flip_manager_properties u_flip_manager_properties (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .cmpt_en_i   (cmpt_en_i),
    .cmpt_idle_i (cmpt_idle_o),
    .cfg_ready_i (spin_configure_ready_o),
    .pop_valid_i (spin_pop_valid_o),
    .pop_spin_i  (spin_pop_o),
    .pop_ready_i (spin_pop_ready_i),
    .flip_ren_i  (flip_ren_o)
);

/* test/tb_ising_flip_top.sv */
// Spin update testbench
`timescale 1ns/1ps

module tb_ising_flip_top;
    import flip_pkg::*;

    localparam logic [31:0] SEED = 32'hc812;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk_i;
    logic rst_n_i;
    logic flush_i;
    logic en_comparison_i;
    logic flip_disable_i;
    logic cmpt_en_i;
    logic cmpt_idle_o;
    logic host_readout_i;
    logic spin_configure_valid_i;
    spin_t spin_configure_i;
    logic spin_configure_ready_o;
    logic spin_pop_valid_o;
    spin_t spin_pop_o;
    logic spin_pop_ready_i;
    logic spin_valid_i;
    spin_t spin_i;
    logic spin_ready_o;
    logic energy_valid_i;
    energy_t energy_i;
    logic energy_ready_o;
    logic icon_we_i;
    logic [ICON_AW-1:0] icon_waddr_i;
    spin_t icon_wdata_i;
    icon_addr_t icon_count_i;

    logic [31:0] lfsr_q = SEED;
    spin_t icons [ICON_DEPTH];
    // Energy model mode flags
    logic stall_on;
    logic readout_on;
    // Spins waiting to be echoed, spins owed an energy, readouts and predictions
    spin_t echo_q [$];
    spin_t nrg_q [$];
    spin_t got_q [$];
    spin_t exp_q [$];
    int error_count = 0;
    int checks_done = 0;
    int tests_run = 0;
    int tests_failed = 0;

    ising_flip_top ising_flip_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_q[0]};
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);
        end
        return val;
    endfunction

    function automatic int ones(input spin_t s);
        int n;
        n = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            n += int'(s[i]);
        end
        return n;
    endfunction

    // Slot s sees addresses s, s+SPIN_DEPTH, ... with its own reference energy
    function automatic spin_t predict(input spin_t start, input int slot,
                                      input logic cmp_on, input logic no_flip);
        spin_t cur;
        spin_t cand;
        int best;
        int nrg;
        cur = start;
        best = (1 << (ENERGY_W - 1)) - 1;
        for (int a = slot; a < ICON_DEPTH; a += SPIN_DEPTH) begin
            cand = no_flip ? cur : cur ^ icons[a];
            nrg = -ones(cand);
            // Ties keep the old spin
            if (!cmp_on || nrg < best) begin
                cur = cand;
                best = nrg;
            end
        end
        return cur;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic flush_fifos();
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
    endtask

    task automatic configure_spin(input spin_t s);
        logic done;
        spin_configure_valid_i = 1'b1;
        spin_configure_i = s;
        done = 1'b0;
        for (int t = 0; t < TIMEOUT_CYCLES && !done; t++) begin
            @(negedge clk_i);
            done = spin_configure_ready_o;
        end
        next_cycle();
        spin_configure_valid_i = 1'b0;
        if (!done) note_failure("configuration port never became ready");
    endtask

    task automatic wait_idle();
        logic done;
        done = 1'b0;
        for (int t = 0; t < TIMEOUT_CYCLES && !done; t++) begin
            @(negedge clk_i);
            done = cmpt_idle_o;
            // Host loads stay locked out while busy
            if (!done) check("config ready while busy", 32'(spin_configure_ready_o), 32'd0);
        end
        if (!done) note_failure("computation did not return to idle in time");
    endtask

    task automatic read_out();
        int target;
        target = checks_done + SPIN_DEPTH;
        next_cycle();
        readout_on = 1'b1;
        host_readout_i = 1'b1;
        for (int t = 0; t < TIMEOUT_CYCLES && checks_done < target; t++) begin
            @(negedge clk_i);
        end
        if (checks_done < target) note_failure("readout did not return every spin in time");
        next_cycle();
        host_readout_i = 1'b0;
        readout_on = 1'b0;
        // Leftovers only remain after a timeout
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic report_test(input string name, input int base);
        tests_run++;
        if (error_count == base) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - base);
        end
    endtask

    task automatic run_cmpt(input string name, input spin_t s0, input spin_t s1,
                            input logic cmp_on, input logic no_flip, input logic stall);
        int base;
        base = error_count;
        flush_fifos();
        en_comparison_i = cmp_on;
        flip_disable_i = no_flip;
        stall_on = stall;
        configure_spin(s0);
        configure_spin(s1);
        exp_q.push_back(predict(s0, 0, cmp_on, no_flip));
        exp_q.push_back(predict(s1, 1, cmp_on, no_flip));
        cmpt_en_i = 1'b1;
        next_cycle();
        cmpt_en_i = 1'b0;
        wait_idle();
        read_out();
        report_test(name, base);
    endtask

    // Energy calculator model, also collects readouts
    initial begin : energy_model
        logic pop_hs;
        logic echo_hs;
        logic nrg_hs;
        logic stall;
        logic readout;
        spin_t popped;
        spin_pop_ready_i = 1'b0;
        spin_valid_i = 1'b0;
        spin_i = '0;
        energy_valid_i = 1'b0;
        energy_i = '0;
        forever begin
            // Handshakes settle mid cycle and complete on the next edge
            @(negedge clk_i);
            pop_hs = spin_pop_valid_o & spin_pop_ready_i;
            echo_hs = spin_valid_i & spin_ready_o;
            nrg_hs = energy_valid_i & energy_ready_o;
            popped = spin_pop_o;
            // Mode flags as seen between edges
            stall = stall_on;
            readout = readout_on;
            next_cycle();
            if (pop_hs && readout) got_q.push_back(popped);
            if (pop_hs && !readout) echo_q.push_back(popped);
            if (echo_hs) spin_valid_i = 1'b0;
            if (nrg_hs) energy_valid_i = 1'b0;
            if (!spin_valid_i && echo_q.size() > 0) begin
                spin_i = echo_q.pop_front();
                spin_valid_i = 1'b1;
                nrg_q.push_back(spin_i);
            end
            // Energy is minus the number of ones
            if (!energy_valid_i && nrg_q.size() > 0 && (!stall || lfsr_bits(1) == 32'd1)) begin
                energy_i = energy_t'(-ones(nrg_q.pop_front()));
                energy_valid_i = 1'b1;
            end
            spin_pop_ready_i = stall ? (lfsr_bits(1) == 32'd1) : 1'b1;
        end
    end

    initial begin : compare_readout
        spin_t got;
        spin_t exp;
        forever begin
            @(negedge clk_i);
            if (got_q.size() > 0 && exp_q.size() > 0) begin
                got = got_q.pop_front();
                exp = exp_q.pop_front();
                check("readout spin", 32'(got), 32'(exp));
                checks_done++;
            end
        end
    end

    initial begin : main
        spin_t s0;
        spin_t s1;
        int base;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        en_comparison_i = 1'b1;
        flip_disable_i = 1'b0;
        cmpt_en_i = 1'b0;
        host_readout_i = 1'b0;
        spin_configure_valid_i = 1'b0;
        spin_configure_i = '0;
        icon_we_i = 1'b0;
        icon_waddr_i = '0;
        icon_wdata_i = '0;
        icon_count_i = icon_addr_t'(ICON_DEPTH);
        stall_on = 1'b0;
        readout_on = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        base = error_count;
        @(negedge clk_i);
        check("idle after reset", 32'(cmpt_idle_o), 32'd1);
        check("pop valid after reset", 32'(spin_pop_valid_o), 32'd0);
        check("icon read after reset", 32'(ising_flip_top_inst.flip_ren), 32'd0);
        check("spin ready after reset", 32'(spin_ready_o), 32'd0);
        check("energy ready after reset", 32'(energy_ready_o), 32'd0);
        report_test("reset", base);

        // Random icon table
        next_cycle();
        for (int i = 0; i < ICON_DEPTH; i++) begin
            icons[i] = spin_t'(lfsr_bits(NUM_SPIN));
            icon_we_i = 1'b1;
            icon_waddr_i = ICON_AW'(i);
            icon_wdata_i = icons[i];
            next_cycle();
        end
        icon_we_i = 1'b0;

        base = error_count;
        flush_fifos();
        s0 = spin_t'(lfsr_bits(NUM_SPIN));
        s1 = spin_t'(lfsr_bits(NUM_SPIN));
        configure_spin(s0);
        configure_spin(s1);
        exp_q.push_back(s0);
        exp_q.push_back(s1);
        read_out();
        report_test("readout only", base);

        s0 = spin_t'(lfsr_bits(NUM_SPIN));
        s1 = spin_t'(lfsr_bits(NUM_SPIN));
        run_cmpt("compare enabled", s0, s1, 1'b1, 1'b0, 1'b0);
        run_cmpt("compare disabled", spin_t'(lfsr_bits(NUM_SPIN)),
                 spin_t'(lfsr_bits(NUM_SPIN)), 1'b0, 1'b0, 1'b0);
        run_cmpt("flip disabled", spin_t'(lfsr_bits(NUM_SPIN)),
                 spin_t'(lfsr_bits(NUM_SPIN)), 1'b1, 1'b1, 1'b0);
        // Same start spins as the compare run with stalls added
        run_cmpt("random stalls", s0, s1, 1'b1, 1'b0, 1'b1);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/flip_pkg.sv
logic/spin_stream_if.sv
logic/energy_fifo_maintainer.sv
logic/spin_fifo_maintainer.sv
logic/flip_engine.sv
logic/flip_icon_mem.sv
logic/flip_manager.sv
logic/ising_flip_top.sv
test/flip_manager_properties.sv
test/tb_ising_flip_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ising_flip_top \
    -f sources.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
